// File: source/fp_cmp_cfg.svh
/*
 * Single-precision format widths, request tag width
 * and Wishbone word-address width
 */
`ifndef FP_CMP_CFG_SVH
`define FP_CMP_CFG_SVH

// IEEE 754 binary32 layout
`define FP_FLEN 32
`define FP_EXPO_WIDTH 8
`define FP_FRAC_WIDTH 23

`define FP_TAG_WIDTH 4 // Host request tag

// Word address, five registers used
`define FP_ADDR_WIDTH 3

`endif

// File: source/fp_format_pkg.sv
/*
 * Floating-point format types: special-case code,
 * shared compare/min/max function code, canonical NaN
 */
`default_nettype none

package fp_format_pkg;

    `include "fp_cmp_cfg.svh"

    // One code per operand, at most one bit set
    typedef struct packed {
        logic snan; // Signaling NaN
        logic qnan; // Quiet NaN
        logic zero; // +0 or -0
    } fp_special_t;

    // Function code as seen by the units
    typedef logic [2:0] fp_fn3_t;

    localparam fp_fn3_t FN3_FLE  = 3'b000;
    localparam fp_fn3_t FN3_FLT  = 3'b001;
    localparam fp_fn3_t FN3_FEQ  = 3'b010;
    localparam fp_fn3_t FN3_FMIN = 3'b000; // Min/max unit reuses the low codes
    localparam fp_fn3_t FN3_FMAX = 3'b001;

    // Quiet NaN with positive sign and only the top fraction bit set
    localparam logic [`FP_FLEN-1:0] CANONICAL_NAN = 32'h7FC0_0000;

endpackage

`default_nettype wire

// File: source/fp_bus_pkg.sv
/*
 * Bus-side types: register map, host operation encoding,
 * command, status and flag field positions
 */
`default_nettype none

package fp_bus_pkg;

    `include "fp_cmp_cfg.svh"

    // Register map, word addresses
    localparam logic [`FP_ADDR_WIDTH-1:0] REG_RS1    = 3'd0;
    localparam logic [`FP_ADDR_WIDTH-1:0] REG_RS2    = 3'd1;
    localparam logic [`FP_ADDR_WIDTH-1:0] REG_CMD    = 3'd2; // Write cmd, read status
    localparam logic [`FP_ADDR_WIDTH-1:0] REG_RESULT = 3'd3; // Read clears valid
    localparam logic [`FP_ADDR_WIDTH-1:0] REG_FFLAGS = 3'd4; // Any write clears

    // Host operation, cmd bits 2:0
    typedef enum logic [2:0] {
        OP_FLE  = 3'd0,
        OP_FLT  = 3'd1,
        OP_FEQ  = 3'd2,
        OP_FMIN = 3'd3,
        OP_FMAX = 3'd4
    } fp_op_t;

    localparam int CMD_OP_LSB       = 0;
    localparam int CMD_TAG_LSB      = 4; // Same place in cmd and status
    localparam int STATUS_VALID_BIT = 8;
    localparam int FFLAGS_NV_BIT    = 4; // Invalid, as in RISC-V fflags

endpackage

`default_nettype wire

// File: source/fp_classify.sv
/*
 * Operand classifier: special-case codes for both operands
 * and the magnitude-order swap bit
 */
`default_nettype none
`timescale 1ns/1ns

`include "fp_cmp_cfg.svh"

module fp_classify (
    input  logic [`FP_FLEN-1:0]       rs1,
    input  logic [`FP_FLEN-1:0]       rs2,
    output fp_format_pkg::fp_special_t rs1_special,
    output fp_format_pkg::fp_special_t rs2_special,
    output logic                      swap
);

    logic [`FP_EXPO_WIDTH-1:0] rs1_expo;
    logic [`FP_EXPO_WIDTH-1:0] rs2_expo;
    logic [`FP_FRAC_WIDTH-1:0] rs1_frac;
    logic [`FP_FRAC_WIDTH-1:0] rs2_frac;
    logic                      rs1_nan;
    logic                      rs2_nan;

    //////////////////////////////////////////////////////////////////////
    // Field unpack
    assign rs1_expo = rs1[`FP_FLEN-2 -: `FP_EXPO_WIDTH];
    assign rs2_expo = rs2[`FP_FLEN-2 -: `FP_EXPO_WIDTH];
    assign rs1_frac = rs1[0 +: `FP_FRAC_WIDTH];
    assign rs2_frac = rs2[0 +: `FP_FRAC_WIDTH];

    //////////////////////////////////////////////////////////////////////
    // Special cases

    // All-ones exponent, nonzero fraction
    assign rs1_nan = (&rs1_expo) & (|rs1_frac);
    assign rs2_nan = (&rs2_expo) & (|rs2_frac);

    // Top fraction bit picks quiet over signaling
    assign rs1_special.snan = rs1_nan & ~rs1_frac[`FP_FRAC_WIDTH-1];
    assign rs1_special.qnan = rs1_nan &  rs1_frac[`FP_FRAC_WIDTH-1];
    assign rs1_special.zero = ~(|rs1_expo) & ~(|rs1_frac); // Either sign

    assign rs2_special.snan = rs2_nan & ~rs2_frac[`FP_FRAC_WIDTH-1];
    assign rs2_special.qnan = rs2_nan &  rs2_frac[`FP_FRAC_WIDTH-1];
    assign rs2_special.zero = ~(|rs2_expo) & ~(|rs2_frac);

    //////////////////////////////////////////////////////////////////////
    // Magnitude order

    // Exponent above fraction, so one unsigned compare covers both
    assign swap = {rs1_expo, rs1_frac} < {rs2_expo, rs2_frac};

endmodule

`default_nettype wire

// File: source/fp_cmp.sv
/*
 * FEQ/FLT/FLE unit, one cycle latency
 * Quiet FEQ, signaling FLT and FLE
 */
`default_nettype none
`timescale 1ns/1ns

`include "fp_cmp_cfg.svh"

module fp_cmp (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       request,
    input  fp_format_pkg::fp_fn3_t     fn3,
    input  logic [`FP_TAG_WIDTH-1:0]   tag,
    input  logic [`FP_FLEN-1:0]        rs1,
    input  logic [`FP_FLEN-1:0]        rs2,
    input  fp_format_pkg::fp_special_t rs1_special,
    input  fp_format_pkg::fp_special_t rs2_special,
    input  logic                       swap,
    output logic                       done,
    output logic [`FP_TAG_WIDTH-1:0]   result_tag,
    output logic [`FP_FLEN-1:0]        result,
    output logic                       invalid
);

    logic rs1_sign, rs2_sign;
    logic sign_equ, expo_equ, frac_equ;
    logic any_nan, any_snan, both_zero;
    logic feq, flt, fle;
    logic cmp_bit; // Selected result before register
    logic invalid_next;

    assign rs1_sign  = rs1[`FP_FLEN-1];
    assign rs2_sign  = rs2[`FP_FLEN-1];
    assign any_nan   = rs1_special.snan | rs1_special.qnan | rs2_special.snan | rs2_special.qnan;
    assign any_snan  = rs1_special.snan | rs2_special.snan;
    assign both_zero = rs1_special.zero & rs2_special.zero;

    //////////////////////////////////////////////////////////////////////
    // Ordering
    assign sign_equ = rs1_sign == rs2_sign;
    assign expo_equ = rs1[`FP_FLEN-2 -: `FP_EXPO_WIDTH] == rs2[`FP_FLEN-2 -: `FP_EXPO_WIDTH];
    assign frac_equ = rs1[0 +: `FP_FRAC_WIDTH] == rs2[0 +: `FP_FRAC_WIDTH];

    assign feq = both_zero | (sign_equ & expo_equ & frac_equ); // +0 == -0

    always_comb begin
        if (sign_equ)
            flt = (swap ^ rs1_sign) & ~feq; // Negatives reverse magnitude order
        else
            flt = rs1_sign & ~both_zero;
    end

    assign fle = flt | feq;

    // Unordered results are always 0
    always_comb begin
        case (fn3)
            fp_format_pkg::FN3_FLT: cmp_bit = flt & ~any_nan;
            fp_format_pkg::FN3_FEQ: cmp_bit = feq & ~any_nan;
            default:                cmp_bit = fle & ~any_nan;
        endcase
    end

    // FEQ flags only sNaN, FLT/FLE flag any NaN
    assign invalid_next = (fn3 == fp_format_pkg::FN3_FEQ) ? any_snan : any_nan;

    //////////////////////////////////////////////////////////////////////
    // Output register
    always_ff @(posedge clk) begin
        if (reset)
            done <= 1'b0;
        else
            done <= request;
    end

    always_ff @(posedge clk) begin
        result_tag <= tag;
        result     <= {{(`FP_FLEN-1){1'b0}}, cmp_bit}; // Zero extend to XLEN
        invalid    <= invalid_next;
    end

endmodule

`default_nettype wire

// File: source/fp_minmax.sv
/*
 * FMIN/FMAX unit, one cycle latency
 * RISC-V NaN propagation and signed-zero order
 */
`default_nettype none
`timescale 1ns/1ns

`include "fp_cmp_cfg.svh"

module fp_minmax (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       request,
    input  fp_format_pkg::fp_fn3_t     fn3,
    input  logic [`FP_TAG_WIDTH-1:0]   tag,
    input  logic [`FP_FLEN-1:0]        rs1,
    input  logic [`FP_FLEN-1:0]        rs2,
    input  fp_format_pkg::fp_special_t rs1_special,
    input  fp_format_pkg::fp_special_t rs2_special,
    input  logic                       swap,
    output logic                       done,
    output logic [`FP_TAG_WIDTH-1:0]   result_tag,
    output logic [`FP_FLEN-1:0]        result,
    output logic                       invalid
);

    logic                rs1_sign, rs2_sign;
    logic                rs1_nan, rs2_nan;
    logic                rs1_lt; // rs1 orders below rs2
    logic                pick_rs1;
    logic [`FP_FLEN-1:0] result_next;

    assign rs1_sign = rs1[`FP_FLEN-1];
    assign rs2_sign = rs2[`FP_FLEN-1];
    assign rs1_nan  = rs1_special.snan | rs1_special.qnan;
    assign rs2_nan  = rs2_special.snan | rs2_special.qnan;

    //////////////////////////////////////////////////////////////////////
    // Ordering
    always_comb begin
        if (rs1_special.zero & rs2_special.zero)
            rs1_lt = rs1_sign & ~rs2_sign; // -0 below +0
        else if (rs1_sign == rs2_sign)
            rs1_lt = swap ^ rs1_sign;
        else
            rs1_lt = rs1_sign;
    end

    assign pick_rs1 = (fn3 == fp_format_pkg::FN3_FMAX) ? ~rs1_lt : rs1_lt;

    // NaN inputs lose to any number
    always_comb begin
        if (rs1_nan & rs2_nan)
            result_next = fp_format_pkg::CANONICAL_NAN;
        else if (rs1_nan)
            result_next = rs2;
        else if (rs2_nan)
            result_next = rs1;
        else
            result_next = pick_rs1 ? rs1 : rs2;
    end

    //////////////////////////////////////////////////////////////////////
    // Output register
    always_ff @(posedge clk) begin
        if (reset)
            done <= 1'b0;
        else
            done <= request;
    end

    always_ff @(posedge clk) begin
        result_tag <= tag;
        result     <= result_next;
        invalid    <= rs1_special.snan | rs2_special.snan; // Only sNaN for min/max
    end

endmodule

`default_nettype wire

// File: source/fp_wb_regs.sv
/*
 * Wishbone classic slave: operand and command registers, issue decode,
 * result capture, status and sticky invalid flag
 */
`default_nettype none
`timescale 1ns/1ns

`include "fp_cmp_cfg.svh"

module fp_wb_regs (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`FP_ADDR_WIDTH-1:0] wb_adr,
    input  logic [`FP_FLEN-1:0]       wb_dat_i,
    output logic [`FP_FLEN-1:0]       wb_dat_o,
    output logic                      wb_ack,
    output logic [`FP_FLEN-1:0]       rs1,
    output logic [`FP_FLEN-1:0]       rs2,
    output logic                      cmp_request,
    output logic                      minmax_request,
    output fp_format_pkg::fp_fn3_t    fn3,
    output logic [`FP_TAG_WIDTH-1:0]  tag,
    input  logic                      cmp_done,
    input  logic [`FP_TAG_WIDTH-1:0]  cmp_tag,
    input  logic [`FP_FLEN-1:0]       cmp_result,
    input  logic                      cmp_invalid,
    input  logic                      minmax_done,
    input  logic [`FP_TAG_WIDTH-1:0]  minmax_tag,
    input  logic [`FP_FLEN-1:0]       minmax_result,
    input  logic                      minmax_invalid
);

    logic                     bus_wr, bus_rd; // Qualified by ack
    logic                     cmd_wr;
    fp_bus_pkg::fp_op_t       cmd_op;
    logic [`FP_FLEN-1:0]      result_q;
    logic [`FP_TAG_WIDTH-1:0] tag_q;
    logic                     valid_q;
    logic                     invalid_q;  // Sticky
    logic                     done_invalid;

    //////////////////////////////////////////////////////////////////////
    // Bus handshake, one wait state
    always_ff @(posedge clk) begin
        if (reset)
            wb_ack <= 1'b0;
        else
            wb_ack <= wb_cyc & wb_stb & ~wb_ack; // Single-cycle ack
    end

    assign bus_wr = wb_cyc & wb_stb & wb_ack & wb_we;
    assign bus_rd = wb_cyc & wb_stb & wb_ack & ~wb_we;
    assign cmd_wr = bus_wr & (wb_adr == fp_bus_pkg::REG_CMD);

    //////////////////////////////////////////////////////////////////////
    // Command decode
    assign cmd_op = fp_bus_pkg::fp_op_t'(wb_dat_i[fp_bus_pkg::CMD_OP_LSB +: 3]);
    assign tag    = wb_dat_i[fp_bus_pkg::CMD_TAG_LSB +: `FP_TAG_WIDTH];

    always_comb begin
        cmp_request    = 1'b0;
        minmax_request = 1'b0;
        fn3            = fp_format_pkg::FN3_FLE;
        case (cmd_op)
            fp_bus_pkg::OP_FLE: cmp_request = cmd_wr;
            fp_bus_pkg::OP_FLT: begin
                cmp_request = cmd_wr;
                fn3         = fp_format_pkg::FN3_FLT;
            end
            fp_bus_pkg::OP_FEQ: begin
                cmp_request = cmd_wr;
                fn3         = fp_format_pkg::FN3_FEQ;
            end
            fp_bus_pkg::OP_FMIN: begin
                minmax_request = cmd_wr;
                fn3            = fp_format_pkg::FN3_FMIN;
            end
            fp_bus_pkg::OP_FMAX: begin
                minmax_request = cmd_wr;
                fn3            = fp_format_pkg::FN3_FMAX;
            end
            default: ; // Undefined op issues nothing
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Registers
    assign done_invalid = (cmp_done & cmp_invalid) | (minmax_done & minmax_invalid);

    always_ff @(posedge clk) begin
        if (reset) begin
            rs1       <= '0;
            rs2       <= '0;
            result_q  <= '0;
            tag_q     <= '0;
            valid_q   <= 1'b0;
            invalid_q <= 1'b0;
        end else begin
            if (bus_wr && wb_adr == fp_bus_pkg::REG_RS1)
                rs1 <= wb_dat_i;
            if (bus_wr && wb_adr == fp_bus_pkg::REG_RS2)
                rs2 <= wb_dat_i;

            // New result wins over a same-cycle read clear
            if (cmp_done) begin
                result_q <= cmp_result;
                tag_q    <= cmp_tag;
                valid_q  <= 1'b1;
            end else if (minmax_done) begin
                result_q <= minmax_result;
                tag_q    <= minmax_tag;
                valid_q  <= 1'b1;
            end else if (bus_rd && wb_adr == fp_bus_pkg::REG_RESULT) begin
                valid_q  <= 1'b0;
            end

            if (bus_wr && wb_adr == fp_bus_pkg::REG_FFLAGS)
                invalid_q <= done_invalid; // Clear, keep a flag arriving now
            else
                invalid_q <= invalid_q | done_invalid;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read mux, valid during ack
    always_comb begin
        wb_dat_o = '0;
        case (wb_adr)
            fp_bus_pkg::REG_RS1:    wb_dat_o = rs1;
            fp_bus_pkg::REG_RS2:    wb_dat_o = rs2;
            fp_bus_pkg::REG_CMD: begin
                wb_dat_o[fp_bus_pkg::STATUS_VALID_BIT]                 = valid_q;
                wb_dat_o[fp_bus_pkg::CMD_TAG_LSB +: `FP_TAG_WIDTH] = tag_q;
            end
            fp_bus_pkg::REG_RESULT: wb_dat_o = result_q;
            fp_bus_pkg::REG_FFLAGS: wb_dat_o[fp_bus_pkg::FFLAGS_NV_BIT] = invalid_q;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: source/fp_cmp_top.sv
/*
 * Compare coprocessor top: bus registers, classifier,
 * compare unit and min/max unit
 */
`default_nettype none
`timescale 1ns/1ns

`include "fp_cmp_cfg.svh"

module fp_cmp_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`FP_ADDR_WIDTH-1:0] wb_adr,
    input  logic [`FP_FLEN-1:0]       wb_dat_i,
    output logic [`FP_FLEN-1:0]       wb_dat_o,
    output logic                      wb_ack
);

    // Operands and classification, shared by both units
    logic [`FP_FLEN-1:0]        rs1, rs2;
    fp_format_pkg::fp_special_t rs1_special, rs2_special;
    logic                       swap;

    // Issue side
    logic                       cmp_request, minmax_request;
    fp_format_pkg::fp_fn3_t     fn3;
    logic [`FP_TAG_WIDTH-1:0]   tag;

    // Completion side, one unit at a time
    logic                       cmp_done, minmax_done;
    logic [`FP_TAG_WIDTH-1:0]   cmp_tag, minmax_tag;
    logic [`FP_FLEN-1:0]        cmp_result, minmax_result;
    logic                       cmp_invalid, minmax_invalid;

    fp_wb_regs regs_i (.*);

    fp_classify classify_i (.rs1, .rs2, .rs1_special, .rs2_special, .swap);

    fp_cmp cmp_i (
        .clk, .reset, .request(cmp_request), .fn3, .tag,
        .rs1, .rs2, .rs1_special, .rs2_special, .swap,
        .done(cmp_done), .result_tag(cmp_tag), .result(cmp_result), .invalid(cmp_invalid)
    );

    fp_minmax minmax_i (
        .clk, .reset, .request(minmax_request), .fn3, .tag,
        .rs1, .rs2, .rs1_special, .rs2_special, .swap,
        .done(minmax_done), .result_tag(minmax_tag), .result(minmax_result),
        .invalid(minmax_invalid)
    );

endmodule

`default_nettype wire

// File: tests/fp_cmp_top_tb.sv
/*
 * Testbench for the compare coprocessor: pattern file replay,
 * random compares, Wishbone bus tasks and result checks
 */
`default_nettype none
`timescale 1ns/1ns

`include "fp_cmp_cfg.svh"

module fp_cmp_top_tb;

    localparam int MAX_PAT = 40;
    localparam int RESET_CYCLES = 8;

    logic                      clk;
    logic                      reset;
    logic                      wb_cyc, wb_stb, wb_we;
    logic [`FP_ADDR_WIDTH-1:0] wb_adr;
    logic [`FP_FLEN-1:0]       wb_dat_i;
    logic [`FP_FLEN-1:0]       wb_dat_o;
    logic                      wb_ack;

    int     errors = 0;
    int     cycles = 0;
    int     limit  = 100000; // Replaced once patterns are counted
    int     n_pat  = 0;
    integer seed   = 48078;

    // Loaded pattern table
    logic [8*20-1:0]     pat_name [0:MAX_PAT-1];
    logic [3:0]          pat_op   [0:MAX_PAT-1]; // 4'hF clears flags
    logic [`FP_FLEN-1:0] pat_a    [0:MAX_PAT-1];
    logic [`FP_FLEN-1:0] pat_b    [0:MAX_PAT-1];
    logic [`FP_FLEN-1:0] pat_res  [0:MAX_PAT-1];
    logic                pat_nv   [0:MAX_PAT-1];

    fp_cmp_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("Errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checking and reference model
    task automatic check(input [8*20-1:0] name, input [8*12-1:0] field,
                         input [31:0] expected, input [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %0s %0s: expected %h, actual %h", name, field, expected, actual);
            errors++;
        end
    endtask

    // +0 and -0 are equal
    function automatic logic ref_eq(input [31:0] a, input [31:0] b);
        ref_eq = (a[30:0] == 0 && b[30:0] == 0) || a == b;
    endfunction

    // Sign-magnitude order
    function automatic logic ref_lt(input [31:0] a, input [31:0] b);
        if (a[30:0] == 0 && b[30:0] == 0)
            ref_lt = 1'b0;
        else if (a[31] != b[31])
            ref_lt = a[31];
        else if (a[31])
            ref_lt = a[30:0] > b[30:0]; // Negatives reverse
        else
            ref_lt = a[30:0] < b[30:0];
    endfunction

    function automatic logic [3:0] op_from_name(input [8*8-1:0] s);
        if (s == "FLE")       op_from_name = {1'b0, fp_bus_pkg::OP_FLE};
        else if (s == "FLT")  op_from_name = {1'b0, fp_bus_pkg::OP_FLT};
        else if (s == "FEQ")  op_from_name = {1'b0, fp_bus_pkg::OP_FEQ};
        else if (s == "FMIN") op_from_name = {1'b0, fp_bus_pkg::OP_FMIN};
        else if (s == "FMAX") op_from_name = {1'b0, fp_bus_pkg::OP_FMAX};
        else if (s == "CLRF") op_from_name = 4'hF;
        else                  op_from_name = 4'hE; // Unknown
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Bus tasks, entered and left at a falling edge
    task automatic bus_cycle(input logic we, input logic [2:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = wdata;
        @(negedge clk);
        while (!wb_ack)
            @(negedge clk);
        rdata = wb_dat_o; // Mid ack cycle
        @(negedge clk);   // Write lands on the edge closing ack
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input logic [2:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic bus_read(input logic [2:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'h0, data);
    endtask

    // Back-to-back status reads until valid
    task automatic poll_valid(output int polls, output logic [31:0] status);
        status = '0;
        polls  = 0;
        while (!status[fp_bus_pkg::STATUS_VALID_BIT]) begin
            bus_read(fp_bus_pkg::REG_CMD, status);
            polls++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // One operation through the register map
    task automatic run_op(input [8*20-1:0] name, input [2:0] op, input [31:0] a,
                          input [31:0] b, input [31:0] exp_res, input logic exp_nv,
                          input [3:0] tag);
        logic [31:0] rdata;
        logic [31:0] cmd;
        int          polls;
        cmd = ({28'h0, tag} << fp_bus_pkg::CMD_TAG_LSB) | ({29'h0, op} << fp_bus_pkg::CMD_OP_LSB);
        bus_write(fp_bus_pkg::REG_RS1, a);
        bus_write(fp_bus_pkg::REG_RS2, b);
        bus_write(fp_bus_pkg::REG_CMD, cmd);
        poll_valid(polls, rdata);
        check(name, "valid delay", 1, polls); // First read acks 2 cycles after cmd ack
        check(name, "tag", tag, rdata[fp_bus_pkg::CMD_TAG_LSB +: `FP_TAG_WIDTH]);
        bus_read(fp_bus_pkg::REG_RESULT, rdata);
        check(name, "result", exp_res, rdata);
        bus_read(fp_bus_pkg::REG_CMD, rdata);
        check(name, "valid clear", 0, rdata[fp_bus_pkg::STATUS_VALID_BIT]);
        bus_read(fp_bus_pkg::REG_FFLAGS, rdata);
        check(name, "invalid", exp_nv, rdata[fp_bus_pkg::FFLAGS_NV_BIT]);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        integer              fd, code, sel, k;
        logic [8*128-1:0]    line;
        logic [8*20-1:0]     nm;
        logic [8*8-1:0]      opn;
        logic [31:0]         a, b, r, rdata;
        logic [2:0]          op;
        logic                nv;
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_i = '0;

        fd = $fopen("tests/fp_cmp_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file tests/fp_cmp_patterns.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                code = $fgets(line, fd);
                if (code != 0) begin
                    code = $sscanf(line, "%s %s %h %h %h %h", nm, opn, a, b, r, nv);
                    if (code == 6 && n_pat < MAX_PAT) begin // Comment lines fail here
                        pat_name[n_pat] = nm;
                        pat_op[n_pat]   = op_from_name(opn);
                        pat_a[n_pat]    = a;
                        pat_b[n_pat]    = b;
                        pat_res[n_pat]  = r;
                        pat_nv[n_pat]   = nv;
                        n_pat++;
                    end
                end
            end
            $fclose(fd);
        end
        limit = (n_pat + 64) * 40 + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Reset values
        bus_read(fp_bus_pkg::REG_CMD, rdata);
        check("reset", "valid", 0, rdata[fp_bus_pkg::STATUS_VALID_BIT]);
        bus_read(fp_bus_pkg::REG_RESULT, rdata);
        check("reset", "result", 0, rdata);
        bus_read(fp_bus_pkg::REG_FFLAGS, rdata);
        check("reset", "fflags", 0, rdata);

        // Directed patterns
        for (int i = 0; i < n_pat; i++) begin
            if (pat_op[i] == 4'hF) begin
                bus_write(fp_bus_pkg::REG_FFLAGS, 32'h1);
                bus_read(fp_bus_pkg::REG_FFLAGS, rdata);
                check(pat_name[i], "invalid", pat_nv[i], rdata[fp_bus_pkg::FFLAGS_NV_BIT]);
            end else if (pat_op[i] == 4'hE) begin
                $display("Pattern %0s names an unknown operation", pat_name[i]);
                errors++;
            end else begin
                run_op(pat_name[i], pat_op[i][2:0], pat_a[i], pat_b[i], pat_res[i],
                       pat_nv[i], i[3:0]);
            end
        end

        // Random compares, no NaN, flags clean
        for (int i = 0; i < 64; i++) begin
            a = $random(seed);
            b = $random(seed);
            if (a[30:23] == 8'hFF) a[30:23] = 8'hFE;
            if (b[30:23] == 8'hFF) b[30:23] = 8'hFE;
            sel = $random(seed) & 7;
            if (sel == 0)
                b = a;                       // Equal pair
            else if (sel == 1) begin
                a = {a[31], 31'h0};          // Signed zeros
                b = {b[31], 31'h0};
            end
            k = $random(seed) & 3;
            case (k)
                0:       op = fp_bus_pkg::OP_FLE;
                2:       op = fp_bus_pkg::OP_FEQ;
                default: op = fp_bus_pkg::OP_FLT;
            endcase
            if (op == fp_bus_pkg::OP_FLE)
                r = {31'h0, ref_lt(a, b) | ref_eq(a, b)};
            else if (op == fp_bus_pkg::OP_FEQ)
                r = {31'h0, ref_eq(a, b)};
            else
                r = {31'h0, ref_lt(a, b)};
            run_op("rand_cmp", op, a, b, r, 1'b0, i[3:0]);
        end

        $display("Checks done, %0d errors", errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: fp_cmp_top.f
+incdir+source
source/fp_format_pkg.sv
source/fp_bus_pkg.sv
source/fp_classify.sv
source/fp_cmp.sv
source/fp_minmax.sv
source/fp_wb_regs.sv
source/fp_cmp_top.sv
tests/fp_cmp_top_tb.sv

// File: tests/fp_cmp_patterns.txt
# name op rs1 rs2 result invalid
# rs1/rs2/result in hex, invalid is the sticky flag after the op; CLRF clears it
flt_pos     FLT  3F800000 40000000 00000001 0
flt_pos_rev FLT  40000000 3F800000 00000000 0
flt_neg     FLT  C0000000 BF800000 00000001 0
fle_mixed   FLE  BF800000 3F800000 00000001 0
fle_equal   FLE  3FC00000 3FC00000 00000001 0
feq_diff    FEQ  3F800000 BF800000 00000000 0
feq_zeros   FEQ  00000000 80000000 00000001 0
fle_zeros   FLE  80000000 00000000 00000001 0
flt_zeros   FLT  80000000 00000000 00000000 0
fmin_zeros  FMIN 00000000 80000000 80000000 0
fmax_zeros  FMAX 80000000 00000000 00000000 0
fmin_neg    FMIN C0400000 3F800000 C0400000 0
feq_qnan    FEQ  7FC00000 3F800000 00000000 0
flt_qnan    FLT  7FC00000 3F800000 00000000 1
fle_sticky  FLE  3F800000 40000000 00000001 1
clr_1       CLRF 00000000 00000000 00000000 0
fle_qnan    FLE  3F800000 7FC00000 00000000 1
clr_2       CLRF 00000000 00000000 00000000 0
feq_snan    FEQ  7F800001 3F800000 00000000 1
clr_3       CLRF 00000000 00000000 00000000 0
fmin_qnan   FMIN 7FC00000 40000000 40000000 0
fmax_qnan   FMAX BF800000 7FC00000 BF800000 0
fmax_2nan   FMAX 7FC00000 7FC00000 7FC00000 0
fmin_snan   FMIN 7F800001 3F800000 3F800000 1
fmin_2nan   FMIN 7F800001 FFC00000 7FC00000 1
clr_4       CLRF 00000000 00000000 00000000 0
